/* hdl/crtc_pkg.sv */
package crtc_pkg;

	// fixed 640x480 raster, 25 MHz class pixel clock
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC_W  = 96;
	localparam int H_BACK    = 48;
	localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC_W + H_BACK;

	localparam int V_VISIBLE = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC_W  = 2;
	localparam int V_BACK    = 33;
	localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC_W + V_BACK;

	// host register indices, 6845 numbering
	localparam logic [4:0] REG_HDISP    = 5'd1;
	localparam logic [4:0] REG_VDISP    = 5'd6;
	localparam logic [4:0] REG_MAXSCAN  = 5'd9;
	localparam logic [4:0] REG_CURSTART = 5'd10;
	localparam logic [4:0] REG_CUREND   = 5'd11;
	localparam logic [4:0] REG_STARTH   = 5'd12;
	localparam logic [4:0] REG_STARTL   = 5'd13;
	localparam logic [4:0] REG_CURH     = 5'd14;
	localparam logic [4:0] REG_CURL     = 5'd15;

	typedef logic [13:0] fs_addr_t;
	typedef logic [4:0]  row_t;
	typedef logic [7:0]  hcount_t;
	typedef logic [6:0]  vcount_t;
	typedef logic [7:0]  byte_t;

	// 0 steady, 1 off, 2 slow blink (frame bit 3), 3 slower blink (frame bit 4)
	typedef logic [1:0]  blink_mode_t;

	typedef struct packed {
		hcount_t     horz_display;
		vcount_t     vert_display;
		row_t        max_scanline;
		blink_mode_t cursor_blink_mode;
		row_t        cursor_start_row;
		row_t        cursor_end_row;
		fs_addr_t    start_address;
		fs_addr_t    cursor_adr;
	} crtc_cfg_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		// inside the visible area
		logic raster_en;
		// single-cycle pulses
		logic end_of_line;
		logic new_screen;
	} vga_tim_t;

endpackage

/* hdl/crtc_regs.sv */
`timescale 1ns/1ps

module crtc_regs (
	input  logic               PIXELCLK,
	input  logic               nRESET,
	input  logic               cpu_sel,
	input  logic               cpu_write,
	input  logic               cpu_rs,
	input  crtc_pkg::byte_t    cpu_wdata,
	output crtc_pkg::byte_t    cpu_rdata,
	output crtc_pkg::crtc_cfg_t cfg
);

	// index of the data register the host talks to
	logic [4:0] addr_reg;
	logic       wr_strobe;

	assign wr_strobe = cpu_sel & cpu_write;

	// address register, loaded when rs is low
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			addr_reg <= '0;
		end else if (wr_strobe && !cpu_rs) begin
			addr_reg <= cpu_wdata[4:0];
		end
	end

	// data registers, each takes only the bits it holds
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			cfg <= '0;
		end else if (wr_strobe && cpu_rs) begin
			case (addr_reg)
				crtc_pkg::REG_HDISP: begin
					cfg.horz_display <= cpu_wdata;
				end
				crtc_pkg::REG_VDISP: begin
					cfg.vert_display <= cpu_wdata[6:0];
				end
				crtc_pkg::REG_MAXSCAN: begin
					cfg.max_scanline <= cpu_wdata[4:0];
				end
				// blink mode sits in bits 6:5 above the start row
				crtc_pkg::REG_CURSTART: begin
					cfg.cursor_blink_mode <= cpu_wdata[6:5];
					cfg.cursor_start_row  <= cpu_wdata[4:0];
				end
				crtc_pkg::REG_CUREND: begin
					cfg.cursor_end_row <= cpu_wdata[4:0];
				end
				crtc_pkg::REG_STARTH: begin
					cfg.start_address[13:8] <= cpu_wdata[5:0];
				end
				crtc_pkg::REG_STARTL: begin
					cfg.start_address[7:0] <= cpu_wdata;
				end
				crtc_pkg::REG_CURH: begin
					cfg.cursor_adr[13:8] <= cpu_wdata[5:0];
				end
				crtc_pkg::REG_CURL: begin
					cfg.cursor_adr[7:0] <= cpu_wdata;
				end
				// anything else is dropped
				default: begin
				end
			endcase
		end
	end

	// only the cursor address reads back
	always_comb begin
		case (addr_reg)
			crtc_pkg::REG_CURH: begin
				cpu_rdata = {2'b00, cfg.cursor_adr[13:8]};
			end
			crtc_pkg::REG_CURL: begin
				cpu_rdata = cfg.cursor_adr[7:0];
			end
			default: begin
				cpu_rdata = '0;
			end
		endcase
	end

endmodule

/* hdl/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing (
	input  logic               PIXELCLK,
	input  logic               nRESET,
	output crtc_pkg::vga_tim_t tim
);

	// sync window edges in pixel and line units
	localparam int HS_START = crtc_pkg::H_VISIBLE + crtc_pkg::H_FRONT;
	localparam int HS_END   = HS_START + crtc_pkg::H_SYNC_W;
	localparam int VS_START = crtc_pkg::V_VISIBLE + crtc_pkg::V_FRONT;
	localparam int VS_END   = VS_START + crtc_pkg::V_SYNC_W;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic       last_pixel;
	logic       last_line;

	assign last_pixel = (h_cnt == 10'(crtc_pkg::H_TOTAL - 1));
	assign last_line  = (v_cnt == 10'(crtc_pkg::V_TOTAL - 1));

	// pixel counter across the line
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			h_cnt <= '0;
		end else if (last_pixel) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// line counter, steps once per line
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			v_cnt <= '0;
		end else if (last_pixel) begin
			if (last_line) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end
	end

	// all outputs registered off the counters, syncs idle high
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			tim.hsync       <= 1'b1;
			tim.vsync       <= 1'b1;
			tim.raster_en   <= 1'b0;
			tim.end_of_line <= 1'b0;
			tim.new_screen  <= 1'b0;
		end else begin
			tim.hsync       <= !(h_cnt >= 10'(HS_START) && h_cnt < 10'(HS_END));
			tim.vsync       <= !(v_cnt >= 10'(VS_START) && v_cnt < 10'(VS_END));
			tim.raster_en   <= (h_cnt < 10'(crtc_pkg::H_VISIBLE)) &&
				(v_cnt < 10'(crtc_pkg::V_VISIBLE));
			tim.end_of_line <= last_pixel;
			// lines up with the end_of_line of the final line
			tim.new_screen  <= last_pixel && last_line;
		end
	end

endmodule

/* hdl/crtc_addr.sv */
`timescale 1ns/1ps

module crtc_addr (
	input  logic                PIXELCLK,
	input  logic                nRESET,
	input  logic                char_clk,
	input  crtc_pkg::crtc_cfg_t cfg,
	input  crtc_pkg::vga_tim_t  tim,
	output crtc_pkg::fs_addr_t  framestore_adr,
	output crtc_pkg::row_t      scanline_row,
	output logic                disen
);

	logic                char_clk_q;
	logic                char_en;
	crtc_pkg::hcount_t   col_cnt;
	crtc_pkg::vcount_t   row_cnt;
	crtc_pkg::fs_addr_t  line_start;
	crtc_pkg::fs_addr_t  next_line_start;
	logic                next_charline;

	// char_clk falling edge, registered to a single-cycle enable
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			char_clk_q <= 1'b0;
			char_en    <= 1'b0;
		end else begin
			char_clk_q <= char_clk;
			char_en    <= char_clk_q & ~char_clk;
		end
	end

	// last scanline of a character row
	assign next_charline = (scanline_row == cfg.max_scanline) && tim.end_of_line;

	assign next_line_start = line_start + crtc_pkg::fs_addr_t'(cfg.horz_display);

	// display window closes when either count runs out
	assign disen = tim.raster_en && (col_cnt != '0) && (row_cnt != '0);

	// characters left on this line
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			col_cnt <= '0;
		end else if (tim.end_of_line) begin
			col_cnt <= cfg.horz_display;
		end else if (char_en && disen) begin
			col_cnt <= col_cnt - 8'd1;
		end
	end

	// character rows left in the frame
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			row_cnt <= '0;
		end else if (tim.new_screen) begin
			row_cnt <= cfg.vert_display;
		end else if (next_charline && row_cnt != '0) begin
			row_cnt <= row_cnt - 7'd1;
		end
	end

	// framestore address and start of the current character row
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			framestore_adr <= '0;
			line_start     <= '0;
		end else if (tim.new_screen) begin
			framestore_adr <= cfg.start_address;
			line_start     <= cfg.start_address;
		end else if (next_charline) begin
			framestore_adr <= next_line_start;
			line_start     <= next_line_start;
		end else if (tim.end_of_line) begin
			// same character row again, one scanline lower
			framestore_adr <= line_start;
		end else if (char_en && disen) begin
			framestore_adr <= framestore_adr + 14'd1;
		end
	end

	// scanline within the character cell
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			scanline_row <= '0;
		end else if (tim.new_screen || next_charline) begin
			scanline_row <= '0;
		end else if (tim.end_of_line) begin
			scanline_row <= scanline_row + 5'd1;
		end
	end

endmodule

/* hdl/crtc_cursor.sv */
`timescale 1ns/1ps

module crtc_cursor (
	input  logic                PIXELCLK,
	input  logic                nRESET,
	input  crtc_pkg::crtc_cfg_t cfg,
	input  crtc_pkg::vga_tim_t  tim,
	input  crtc_pkg::fs_addr_t  framestore_adr,
	input  crtc_pkg::row_t      scanline_row,
	input  logic                disen,
	output logic                cursor
);

	logic [4:0] frame_cnt;
	logic       cursor_on;
	logic       at_cursor;
	logic       in_band;

	// frame counter and blink phase, both step at new_screen
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			frame_cnt <= '0;
			cursor_on <= 1'b0;
		end else if (tim.new_screen) begin
			frame_cnt <= frame_cnt + 5'd1;
			case (cfg.cursor_blink_mode)
				2'd0: cursor_on <= 1'b1;
				2'd1: cursor_on <= 1'b0;
				2'd2: cursor_on <= frame_cnt[3];
				default: cursor_on <= frame_cnt[4];
			endcase
		end
	end

	assign at_cursor = (framestore_adr == cfg.cursor_adr) && disen;

	// inclusive scanline band
	assign in_band = (scanline_row >= cfg.cursor_start_row) &&
		(scanline_row <= cfg.cursor_end_row);

	assign cursor = cursor_on && at_cursor && in_band;

endmodule

/* hdl/crtc_top.sv */
`timescale 1ns/1ps

module crtc_top (
	input  logic               PIXELCLK,
	input  logic               nRESET,
	input  logic               char_clk,
	input  logic               cpu_sel,
	input  logic               cpu_write,
	input  logic               cpu_rs,
	input  crtc_pkg::byte_t    cpu_wdata,
	output crtc_pkg::byte_t    cpu_rdata,
	output crtc_pkg::fs_addr_t framestore_adr,
	output crtc_pkg::row_t     scanline_row,
	output logic               disen,
	output logic               h_sync,
	output logic               v_sync,
	output logic               cursor
);

	crtc_pkg::crtc_cfg_t cfg;
	crtc_pkg::vga_tim_t  tim;

	crtc_regs regs0 (
		.PIXELCLK  (PIXELCLK),
		.nRESET    (nRESET),
		.cpu_sel   (cpu_sel),
		.cpu_write (cpu_write),
		.cpu_rs    (cpu_rs),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.cfg       (cfg)
	);

	vga_timing timing0 (
		.PIXELCLK (PIXELCLK),
		.nRESET   (nRESET),
		.tim      (tim)
	);

	crtc_addr addr0 (
		.PIXELCLK       (PIXELCLK),
		.nRESET         (nRESET),
		.char_clk       (char_clk),
		.cfg            (cfg),
		.tim            (tim),
		.framestore_adr (framestore_adr),
		.scanline_row   (scanline_row),
		.disen          (disen)
	);

	crtc_cursor cursor0 (
		.PIXELCLK       (PIXELCLK),
		.nRESET         (nRESET),
		.cfg            (cfg),
		.tim            (tim),
		.framestore_adr (framestore_adr),
		.scanline_row   (scanline_row),
		.disen          (disen),
		.cursor         (cursor)
	);

	// syncs come straight from the raster block
	assign h_sync = tim.hsync;
	assign v_sync = tim.vsync;

endmodule

/* include/crtc_tb_checks.svh */
`ifndef CRTC_TB_CHECKS_SVH
`define CRTC_TB_CHECKS_SVH

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per bit taken
task automatic take_bits(input int n, output logic [15:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[14:0], lfsr_state[15]};
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

task automatic begin_test(input string name);
	test_name = name;
	errors_before = errors;
	tests++;
endtask

task automatic end_test();
	if (errors == errors_before) begin
		$display("test %s: ok", test_name);
	end else begin
		$display("test %s: %0d errors", test_name, errors - errors_before);
	end
endtask

task automatic check_byte(input string what, input crtc_pkg::byte_t exp,
		input crtc_pkg::byte_t act);
	checks++;
	if (exp !== act) begin
		errors++;
		$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
	end
endtask

task automatic check_addr(input string what, input crtc_pkg::fs_addr_t exp,
		input crtc_pkg::fs_addr_t act);
	checks++;
	if (exp !== act) begin
		errors++;
		$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
	end
endtask

task automatic check_row(input string what, input crtc_pkg::row_t exp,
		input crtc_pkg::row_t act);
	checks++;
	if (exp !== act) begin
		errors++;
		$display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
	end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
	checks++;
	if (exp !== act) begin
		errors++;
		$display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
	end
endtask

task automatic check_count(input string what, input int exp, input int act);
	checks++;
	if (exp != act) begin
		errors++;
		$display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
	end
endtask

// address phase then data phase
task automatic write_reg(input logic [4:0] idx, input crtc_pkg::byte_t data);
	@(posedge PIXELCLK);
	#1;
	cpu_sel   = 1'b1;
	cpu_write = 1'b1;
	cpu_rs    = 1'b0;
	cpu_wdata = {3'b000, idx};
	@(posedge PIXELCLK);
	#1;
	cpu_rs    = 1'b1;
	cpu_wdata = data;
	@(posedge PIXELCLK);
	#1;
	cpu_sel   = 1'b0;
	cpu_write = 1'b0;
	cpu_rs    = 1'b0;
endtask

task automatic select_reg(input logic [4:0] idx);
	@(posedge PIXELCLK);
	#1;
	cpu_sel   = 1'b1;
	cpu_write = 1'b1;
	cpu_rs    = 1'b0;
	cpu_wdata = {3'b000, idx};
	@(posedge PIXELCLK);
	#1;
	cpu_sel   = 1'b0;
	cpu_write = 1'b0;
	@(negedge PIXELCLK);
endtask

task automatic set_display(input int start, input int horz, input int vert, input int maxs);
	cfg_start = start;
	cfg_horz  = horz;
	cfg_vert  = vert;
	cfg_max   = maxs;
	write_reg(crtc_pkg::REG_HDISP, horz[7:0]);
	write_reg(crtc_pkg::REG_VDISP, vert[7:0]);
	write_reg(crtc_pkg::REG_MAXSCAN, maxs[7:0]);
	write_reg(crtc_pkg::REG_STARTH, {2'b00, start[13:8]});
	write_reg(crtc_pkg::REG_STARTL, start[7:0]);
endtask

// blink mode rides in bits 6:5 of the cursor start register
task automatic set_cursor(input crtc_pkg::fs_addr_t adr, input logic [1:0] mode,
		input int rs, input int re);
	cur_adr   = adr;
	cur_start = rs;
	cur_end   = re;
	write_reg(crtc_pkg::REG_CURSTART, {1'b0, mode, rs[4:0]});
	write_reg(crtc_pkg::REG_CUREND, {3'b000, re[4:0]});
	write_reg(crtc_pkg::REG_CURH, {2'b00, adr[13:8]});
	write_reg(crtc_pkg::REG_CURL, adr[7:0]);
endtask

// watch one visible frame from a v_sync rise to the next v_sync fall
task automatic watch_frame(output int lines, output int cur_lines, output int frame_idx);
	int   start_rises;
	int   chars;
	int   pitch;
	logic prev_disen;
	logic prev_cur;
	logic in_band;
	start_rises = vsync_rises;
	lines = 0;
	cur_lines = 0;
	chars = 0;
	pitch = cfg_max + 1;
	prev_disen = 1'b0;
	prev_cur = 1'b0;
	while (vsync_rises == start_rises) begin
		@(negedge PIXELCLK);
	end
	frame_idx = vsync_rises;
	while (v_sync) begin
		if (disen && !prev_disen) begin
			check_addr("line start",
				crtc_pkg::fs_addr_t'(cfg_start + cfg_horz * (lines / pitch)),
				framestore_adr);
			check_row("scanline", crtc_pkg::row_t'(lines % pitch), scanline_row);
			lines++;
			chars = 0;
		end
		if (disen && char_en_model) begin
			chars++;
		end
		if (!disen && prev_disen) begin
			check_count("chars per line", cfg_horz, chars);
		end
		if (cursor) begin
			in_band = (int'(scanline_row) >= cur_start) && (int'(scanline_row) <= cur_end);
			check_addr("cursor position", cur_adr, framestore_adr);
			check_bit("cursor band", 1'b1, in_band);
		end
		if (cursor && !prev_cur) begin
			cur_lines++;
		end
		prev_disen = disen;
		prev_cur = cursor;
		@(negedge PIXELCLK);
	end
endtask

task automatic reset_values();
	begin_test("reset");
	repeat (3) @(posedge PIXELCLK);
	@(negedge PIXELCLK);
	check_bit("disen in reset", 1'b0, disen);
	check_bit("cursor in reset", 1'b0, cursor);
	check_addr("address in reset", '0, framestore_adr);
	check_row("row in reset", '0, scanline_row);
	check_bit("h_sync in reset", 1'b1, h_sync);
	check_bit("v_sync in reset", 1'b1, v_sync);
	repeat (2) @(posedge PIXELCLK);
	#1;
	nRESET = 1'b1;
	@(negedge PIXELCLK);
	check_bit("disen after reset", 1'b0, disen);
	check_bit("cursor after reset", 1'b0, cursor);
	check_addr("address after reset", '0, framestore_adr);
	check_row("row after reset", '0, scanline_row);
	check_bit("h_sync after reset", 1'b1, h_sync);
	check_bit("v_sync after reset", 1'b1, v_sync);
	end_test();
endtask

task automatic register_readback();
	logic [15:0] hi;
	logic [15:0] lo;
	begin_test("readback");
	for (int i = 0; i < 4; i++) begin
		take_bits(8, hi);
		take_bits(8, lo);
		write_reg(crtc_pkg::REG_CURH, hi[7:0]);
		write_reg(crtc_pkg::REG_CURL, lo[7:0]);
		select_reg(crtc_pkg::REG_CURH);
		check_byte("cursor high", {2'b00, hi[5:0]}, cpu_rdata);
		select_reg(crtc_pkg::REG_CURL);
		check_byte("cursor low", lo[7:0], cpu_rdata);
	end
	select_reg(5'd3);
	check_byte("unlisted index", 8'h00, cpu_rdata);
	end_test();
endtask

task automatic sync_widths();
	int   n;
	int   m;
	logic prev;
	begin_test("raster");
	do begin
		prev = h_sync;
		@(negedge PIXELCLK);
	end while (!(prev && !h_sync));
	n = 0;
	m = 0;
	while (!h_sync) begin
		n++;
		@(negedge PIXELCLK);
	end
	while (h_sync) begin
		m++;
		@(negedge PIXELCLK);
	end
	check_count("h_sync width", crtc_pkg::H_SYNC_W, n);
	check_count("line period", crtc_pkg::H_TOTAL, n + m);
	do begin
		prev = v_sync;
		@(negedge PIXELCLK);
	end while (!(prev && !v_sync));
	n = 0;
	while (!v_sync) begin
		n++;
		@(negedge PIXELCLK);
	end
	check_count("v_sync width", crtc_pkg::V_SYNC_W * crtc_pkg::H_TOTAL, n);
	end_test();
endtask

task automatic address_rows();
	int lines;
	int cur_lines;
	int idx;
	begin_test("address");
	set_cursor(14'h3fff, 2'd1, 0, 0);
	set_display(14'h123, 10, 4, 7);
	watch_frame(lines, cur_lines, idx);
	check_count("display lines", 4 * 8, lines);
	end_test();
endtask

task automatic display_window();
	logic [15:0] start;
	int          lines;
	int          cur_lines;
	int          idx;
	begin_test("window");
	take_bits(14, start);
	set_display(int'(start[13:0]), 20, 3, 3);
	watch_frame(lines, cur_lines, idx);
	check_count("display lines", 3 * 4, lines);
	end_test();
endtask

task automatic cursor_modes();
	int lines;
	int cur_lines;
	int idx;
	int expected;
	begin_test("cursor");
	set_display(14'h040, 10, 4, 7);
	// cursor on the second character row and fourth column over scanlines 2 to 4
	set_cursor(14'h040 + 14'd13, 2'd0, 2, 4);
	watch_frame(lines, cur_lines, idx);
	check_count("steady cursor lines", 3, cur_lines);
	set_cursor(14'h040 + 14'd13, 2'd1, 2, 4);
	watch_frame(lines, cur_lines, idx);
	check_count("cursor off lines", 0, cur_lines);
	set_cursor(14'h040 + 14'd13, 2'd2, 2, 4);
	// frame after the k-th new screen shows bit 3 of k-1
	do begin
		watch_frame(lines, cur_lines, idx);
		expected = ((idx - 1) & 8) != 0 ? 3 : 0;
		check_count("blink cursor lines", expected, cur_lines);
	end while (((idx - 1) & 8) == 0);
	end_test();
endtask

`endif

/* verification/crtc_tb.sv */
`timescale 1ns/1ps

module crtc_tb;

	localparam int CLK_PERIOD = 4;
	localparam longint WATCHDOG_NS =
		64'd20 * crtc_pkg::H_TOTAL * crtc_pkg::V_TOTAL * CLK_PERIOD;

	logic               PIXELCLK = 1'b0;
	logic               nRESET;
	logic               char_clk;
	logic               cpu_sel;
	logic               cpu_write;
	logic               cpu_rs;
	crtc_pkg::byte_t    cpu_wdata;
	crtc_pkg::byte_t    cpu_rdata;
	crtc_pkg::fs_addr_t framestore_adr;
	crtc_pkg::row_t     scanline_row;
	logic               disen;
	logic               h_sync;
	logic               v_sync;
	logic               cursor;

	// divide-by-8 character clock driven 1 ns after the edge
	logic [2:0] char_div = 3'd0;
	// own copy of the char_clk falling edge enable
	logic       char_q = 1'b0;
	logic       char_en_model = 1'b0;
	// count of v_sync rising edges since reset
	int         vsync_rises = 0;
	logic       vsync_q = 1'b1;

	logic [15:0] lfsr_state = 16'd69;

	string test_name;
	int    errors = 0;
	int    checks = 0;
	int    tests = 0;
	int    errors_before;

	// display and cursor setup as last programmed
	int                 cfg_start;
	int                 cfg_horz;
	int                 cfg_vert;
	int                 cfg_max;
	crtc_pkg::fs_addr_t cur_adr;
	int                 cur_start;
	int                 cur_end;

	always #(CLK_PERIOD / 2) PIXELCLK = ~PIXELCLK;

	always @(posedge PIXELCLK) begin
		char_div <= #1 char_div + 3'd1;
	end

	assign char_clk = char_div[2];

	always @(posedge PIXELCLK) begin
		char_q        <= char_clk;
		char_en_model <= char_q & ~char_clk;
	end

	always @(negedge PIXELCLK) begin
		if (nRESET) begin
			vsync_q <= v_sync;
			if (v_sync && !vsync_q) begin
				vsync_rises <= vsync_rises + 1;
			end
		end
	end

	crtc_top dut0 (
		.PIXELCLK       (PIXELCLK),
		.nRESET         (nRESET),
		.char_clk       (char_clk),
		.cpu_sel        (cpu_sel),
		.cpu_write      (cpu_write),
		.cpu_rs         (cpu_rs),
		.cpu_wdata      (cpu_wdata),
		.cpu_rdata      (cpu_rdata),
		.framestore_adr (framestore_adr),
		.scanline_row   (scanline_row),
		.disen          (disen),
		.h_sync         (h_sync),
		.v_sync         (v_sync),
		.cursor         (cursor)
	);

	`include "crtc_tb_checks.svh"

	initial begin
		nRESET    = 1'b0;
		cpu_sel   = 1'b0;
		cpu_write = 1'b0;
		cpu_rs    = 1'b0;
		cpu_wdata = '0;
		reset_values();
		register_readback();
		sync_widths();
		address_rows();
		display_window();
		cursor_modes();
		$display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog of 20 full frames
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within 20 frames");
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
hdl/crtc_pkg.sv
hdl/crtc_regs.sv
hdl/vga_timing.sv
hdl/crtc_addr.sv
hdl/crtc_cursor.sv
hdl/crtc_top.sv
verification/crtc_tb.sv

/* Bender.yml */
package:
  name: crtc

sources:
  - files:
      - hdl/crtc_pkg.sv
      - hdl/crtc_regs.sv
      - hdl/vga_timing.sv
      - hdl/crtc_addr.sv
      - hdl/crtc_cursor.sv
      - hdl/crtc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/crtc_tb.sv
